// File: hw/tpu_cmd_pkg.sv
package tpu_cmd_pkg;

    // opcode field and command parameter widths
    localparam int CMD_W   = 8;
    localparam int PARAM_W = 32;

    // kept commands, values shared with the software driver
    typedef enum logic [CMD_W-1:0] {
        TRIGGER_CONV    = 8'd1,
        SW_WRITE_DATA   = 8'd9,
        SW_WRITE_WEIGHT = 8'd10,
        SET_KMN         = 8'd13,
        SW_READ_DATA    = 8'd14
    } opcode_t;

    // SET_KMN parameter 1
    typedef enum logic [1:0] {
        KMN_K = 2'd0,
        KMN_M = 2'd1,
        KMN_N = 2'd2
    } kmn_sel_t;

endpackage

// File: hw/tpu_data_pkg.sv
package tpu_data_pkg;

    // edge of the MAC array and bank count of each buffer
    localparam int LANES = 4;

    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;

    // one result row, column 0 in the top bits
    typedef logic [LANES*WORD_W-1:0] res_row_t;

endpackage

// File: hw/tile_if.sv
`timescale 1ns/10ps

interface tile_if #(
    parameter int ADDR_W = 10,
    parameter int TILE_W = 6
);
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [TILE_W-1:0] tile_idx_t;

    // strobes from the sequencer
    logic      tile_start;
    logic      k_step;
    logic      tile_advance;
    logic      conv_start;

    // status and addresses from the counter
    logic      k_last;
    logic      conv_done;
    addr_t     rd_addr_a;
    addr_t     rd_addr_b;
    tile_idx_t store_idx;

    modport fsm (
        output tile_start, k_step, tile_advance, conv_start,
        input  k_last, conv_done
    );

    modport cnt (
        input  tile_start, k_step, tile_advance, conv_start,
        output k_last, conv_done, rd_addr_a, rd_addr_b, store_idx
    );

endinterface

// File: hw/tpu_ctrl_fsm.sv
`timescale 1ns/10ps

module tpu_ctrl_fsm
    import tpu_cmd_pkg::*;
    import tpu_data_pkg::*;
#(
    parameter int ADDR_W = 10,
    parameter int TILE_W = 6
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                cmd_valid_i,
    input  opcode_t             cmd_i,
    input  word_t               param_1_i,
    input  word_t               param_2_i,
    tile_if.fsm                 tile,
    output logic                a_we_o,
    output logic                b_we_o,
    output logic                kmn_we_o,
    output logic [1:0]          wr_bank_o,
    output logic [ADDR_W-1:0]   wr_addr_o,
    output word_t               wr_data_o,
    output logic                acc_clear_o,
    output logic                acc_en_o,
    output logic                store_o,
    output logic                rd_req_o,
    output logic [3:0]          rd_elem_o,
    output logic [TILE_W-1:0]   rd_tile_o,
    output logic                tpu_busy_o,
    output logic                ret_valid_o
);

    typedef enum logic [2:0] {
        IDLE, TILE_START, ACCUM, DRAIN, STORE, RD_ADDR, RD_DATA, RD_OUT
    } state_t;

    state_t state, state_nxt;
    logic   accept;

    // commands only count while nothing is running
    assign accept = cmd_valid_i && !tpu_busy_o;

    //##################################################
    // state register and next state
    //##################################################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept && cmd_i == TRIGGER_CONV) begin
                    state_nxt = TILE_START;
                end else if (accept && cmd_i == SW_READ_DATA) begin
                    state_nxt = RD_ADDR;
                end
            end
            TILE_START: state_nxt = ACCUM;
            ACCUM:      state_nxt = tile.k_last ? DRAIN : ACCUM;
            // last product still in flight
            DRAIN:      state_nxt = STORE;
            STORE:      state_nxt = tile.conv_done ? IDLE : TILE_START;
            RD_ADDR:    state_nxt = RD_DATA;
            RD_DATA:    state_nxt = RD_OUT;
            RD_OUT:     state_nxt = IDLE;
            default:    state_nxt = IDLE;
        endcase
    end

    //##################################################
    // software writes and readout target
    //##################################################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            a_we_o   <= 1'b0;
            b_we_o   <= 1'b0;
            kmn_we_o <= 1'b0;
        end else begin
            a_we_o   <= accept && cmd_i == SW_WRITE_DATA;
            b_we_o   <= accept && cmd_i == SW_WRITE_WEIGHT;
            kmn_we_o <= accept && cmd_i == SET_KMN;
        end
    end

    // bank field doubles as the K/M/N select
    always_ff @(posedge clk_i) begin
        if (accept && cmd_i == SET_KMN) begin
            wr_bank_o <= param_1_i[1:0];
            wr_data_o <= param_2_i;
        end else if (accept) begin
            wr_bank_o <= param_2_i[1:0];
            wr_addr_o <= param_2_i[ADDR_W+1:2];
            wr_data_o <= param_1_i;
        end
        if (accept && cmd_i == SW_READ_DATA) begin
            rd_elem_o <= param_1_i[3:0];
            rd_tile_o <= param_2_i[TILE_W-1:0];
        end
    end

    //##################################################
    // sequencing strobes
    //##################################################
    assign tile.conv_start   = accept && cmd_i == TRIGGER_CONV;
    assign tile.tile_start   = state == TILE_START;
    assign tile.k_step       = state == ACCUM;
    assign tile.tile_advance = state == STORE;

    assign acc_clear_o = state == TILE_START;
    assign acc_en_o    = state == ACCUM;
    assign store_o     = state == STORE;
    assign rd_req_o    = state == RD_DATA;

    // pulse lines up with the result buffer output stage
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ret_valid_o <= 1'b0;
        end else begin
            ret_valid_o <= state == RD_OUT;
        end
    end

    assign tpu_busy_o = (state != IDLE) || ret_valid_o;

endmodule

// File: hw/tile_counter.sv
`timescale 1ns/10ps

module tile_counter
    import tpu_cmd_pkg::*;
    import tpu_data_pkg::*;
#(
    parameter int ADDR_W = 10,
    parameter int TILE_W = 6
) (
    input  logic     clk_i,
    input  logic     rst_i,
    tile_if.cnt      tile,
    input  logic     kmn_we_i,
    input  kmn_sel_t kmn_sel_i,
    input  word_t    kmn_val_i
);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [TILE_W-1:0] tile_idx_t;

    addr_t             k_reg, m_reg, n_reg;
    addr_t             k_cnt;
    addr_t             base_a, base_b;
    logic [ADDR_W-3:0] t_r, t_c;
    logic [ADDR_W-3:0] row_last, col_last;
    tile_idx_t         store_idx;

    //##################################################
    // matrix sizes
    //##################################################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            k_reg <= '0;
            m_reg <= '0;
            n_reg <= '0;
        end else if (kmn_we_i) begin
            case (kmn_sel_i)
                KMN_K:   k_reg <= kmn_val_i[ADDR_W-1:0];
                KMN_M:   m_reg <= kmn_val_i[ADDR_W-1:0];
                KMN_N:   n_reg <= kmn_val_i[ADDR_W-1:0];
                default: k_reg <= k_reg;
            endcase
        end
    end

    // last tile index in each direction
    assign row_last = m_reg[ADDR_W-1:2] - 1'b1;
    assign col_last = n_reg[ADDR_W-1:2] - 1'b1;

    //##################################################
    // k and tile counters
    //##################################################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            k_cnt <= '0;
        end else if (tile.tile_start) begin
            k_cnt <= '0;
        end else if (tile.k_step) begin
            k_cnt <= k_cnt + 1'b1;
        end
    end

    // bases track t_r*K and t_c*K without a multiplier
    always_ff @(posedge clk_i) begin
        if (rst_i || tile.conv_start) begin
            t_r       <= '0;
            t_c       <= '0;
            base_a    <= '0;
            base_b    <= '0;
            store_idx <= '0;
        end else if (tile.tile_advance) begin
            store_idx <= store_idx + 1'b1;
            if (t_r == row_last) begin
                t_r    <= '0;
                base_a <= '0;
                t_c    <= t_c + 1'b1;
                base_b <= base_b + k_reg;
            end else begin
                t_r    <= t_r + 1'b1;
                base_a <= base_a + k_reg;
            end
        end
    end

    assign tile.rd_addr_a = base_a + k_cnt;
    assign tile.rd_addr_b = base_b + k_cnt;
    assign tile.k_last    = k_cnt == k_reg - 1'b1;
    assign tile.conv_done = (t_r == row_last) && (t_c == col_last);
    assign tile.store_idx = store_idx;

endmodule

// File: hw/operand_buffer.sv
`timescale 1ns/10ps

module operand_buffer
    import tpu_data_pkg::*;
#(
    parameter int ADDR_W = 10
) (
    input  logic              clk_i,
    input  logic              we_i,
    input  logic [1:0]        wr_bank_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  word_t             wr_data_i,
    input  logic [ADDR_W-1:0] rd_addr_i,
    output word_t             rd_data_o [LANES]
);

    localparam int DEPTH = 2 ** ADDR_W;

    // one bank per lane, all read at the same address
    for (genvar i = 0; i < LANES; i++) begin : g_bank
        word_t mem [DEPTH];

        always_ff @(posedge clk_i) begin
            if (we_i && wr_bank_i == i) begin
                mem[wr_addr_i] <= wr_data_i;
            end
            rd_data_o[i] <= mem[rd_addr_i];
        end
    end

endmodule

// File: hw/mac_array.sv
`timescale 1ns/10ps

module mac_array
    import tpu_data_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     acc_clear_i,
    input  logic     acc_en_i,
    input  word_t    a_i    [LANES],
    input  word_t    b_i    [LANES],
    output res_row_t rows_o [LANES]
);

    logic  acc_en_q;
    word_t acc [LANES][LANES];

    // operands arrive one cycle after their address
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            acc_en_q <= 1'b0;
        end else begin
            acc_en_q <= acc_en_i;
        end
    end

    //##################################################
    // sixteen accumulators, wrap at 32 bits
    //##################################################
    always_ff @(posedge clk_i) begin
        for (int r = 0; r < LANES; r++) begin
            for (int c = 0; c < LANES; c++) begin
                if (acc_clear_i) begin
                    acc[r][c] <= '0;
                end else if (acc_en_q) begin
                    acc[r][c] <= acc[r][c] + a_i[r] * b_i[c];
                end
            end
        end
    end

    for (genvar r = 0; r < LANES; r++) begin : g_row
        assign rows_o[r] = {acc[r][0], acc[r][1], acc[r][2], acc[r][3]};
    end

endmodule

// File: hw/result_buffer.sv
`timescale 1ns/10ps

module result_buffer
    import tpu_data_pkg::*;
#(
    parameter int TILE_W = 6
) (
    input  logic              clk_i,
    input  logic              store_i,
    input  logic [TILE_W-1:0] store_idx_i,
    input  res_row_t          rows_i [LANES],
    input  logic              rd_req_i,
    input  logic [TILE_W-1:0] rd_tile_i,
    input  logic [3:0]        rd_elem_i,
    output word_t             rd_data_o
);

    localparam int DEPTH = 2 ** TILE_W;

    res_row_t   mem [LANES][DEPTH];
    res_row_t   row_q;
    logic [1:0] col_q;
    logic       req_q;

    //##################################################
    // tile store and row read
    //##################################################
    always_ff @(posedge clk_i) begin
        if (store_i) begin
            for (int r = 0; r < LANES; r++) begin
                mem[r][store_idx_i] <= rows_i[r];
            end
        end
        row_q <= mem[rd_elem_i[3:2]][rd_tile_i];
        col_q <= rd_elem_i[1:0];
        req_q <= rd_req_i;
    end

    // word select, zero outside a read
    always_ff @(posedge clk_i) begin
        if (req_q) begin
            rd_data_o <= row_q[(LANES-1-col_q)*32 +: 32];
        end else begin
            rd_data_o <= '0;
        end
    end

endmodule

// File: hw/tpu_top.sv
`timescale 1ns/10ps

module tpu_top
    import tpu_cmd_pkg::*;
    import tpu_data_pkg::*;
#(
    parameter int ADDR_W = 10,
    parameter int TILE_W = 6
) (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               cmd_valid_i,
    input  logic [CMD_W-1:0]   cmd_i,
    input  logic [PARAM_W-1:0] param_1_i,
    input  logic [PARAM_W-1:0] param_2_i,
    output logic               ret_valid_o,
    output logic [PARAM_W-1:0] ret_data_o,
    output logic               tpu_busy_o
);

    tile_if #(.ADDR_W(ADDR_W), .TILE_W(TILE_W)) tile ();

    logic              a_we, b_we, kmn_we;
    logic [1:0]        wr_bank;
    logic [ADDR_W-1:0] wr_addr;
    word_t             wr_data;
    logic              acc_clear, acc_en, store, rd_req;
    logic [3:0]        rd_elem;
    logic [TILE_W-1:0] rd_tile;
    word_t             a_data [LANES];
    word_t             b_data [LANES];
    res_row_t          rows   [LANES];

    //##################################################
    // control
    //##################################################
    tpu_ctrl_fsm #(.ADDR_W(ADDR_W), .TILE_W(TILE_W)) u_fsm (
        .clk_i, .rst_i, .cmd_valid_i,
        .cmd_i       (opcode_t'(cmd_i)),
        .param_1_i, .param_2_i,
        .tile        (tile.fsm),
        .a_we_o      (a_we),      .b_we_o     (b_we),     .kmn_we_o (kmn_we),
        .wr_bank_o   (wr_bank),   .wr_addr_o  (wr_addr),  .wr_data_o(wr_data),
        .acc_clear_o (acc_clear), .acc_en_o   (acc_en),
        .store_o     (store),     .rd_req_o   (rd_req),
        .rd_elem_o   (rd_elem),   .rd_tile_o  (rd_tile),
        .tpu_busy_o, .ret_valid_o
    );

    tile_counter #(.ADDR_W(ADDR_W), .TILE_W(TILE_W)) u_cnt (
        .clk_i, .rst_i,
        .tile      (tile.cnt),
        .kmn_we_i  (kmn_we),
        .kmn_sel_i (kmn_sel_t'(wr_bank)),
        .kmn_val_i (wr_data)
    );

    //##################################################
    // datapath
    //##################################################
    operand_buffer #(.ADDR_W(ADDR_W)) u_data_buf (
        .clk_i, .we_i(a_we), .wr_bank_i(wr_bank), .wr_addr_i(wr_addr),
        .wr_data_i(wr_data), .rd_addr_i(tile.rd_addr_a), .rd_data_o(a_data)
    );

    operand_buffer #(.ADDR_W(ADDR_W)) u_weight_buf (
        .clk_i, .we_i(b_we), .wr_bank_i(wr_bank), .wr_addr_i(wr_addr),
        .wr_data_i(wr_data), .rd_addr_i(tile.rd_addr_b), .rd_data_o(b_data)
    );

    mac_array u_mac (
        .clk_i, .rst_i,
        .acc_clear_i (acc_clear),
        .acc_en_i    (acc_en),
        .a_i         (a_data),
        .b_i         (b_data),
        .rows_o      (rows)
    );

    result_buffer #(.TILE_W(TILE_W)) u_res_buf (
        .clk_i,
        .store_i     (store),
        .store_idx_i (tile.store_idx),
        .rows_i      (rows),
        .rd_req_i    (rd_req),
        .rd_tile_i   (rd_tile),
        .rd_elem_i   (rd_elem),
        .rd_data_o   (ret_data_o)
    );

endmodule

// File: bench/tpu_checker.sv
`timescale 1ns/10ps

module tpu_checker
    import tpu_cmd_pkg::*;
    import tpu_data_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             cmd_valid_i,
    input  logic [CMD_W-1:0] cmd_i,
    input  logic             busy_i,
    input  logic             ret_valid_i,
    input  word_t            ret_data_i,
    input  word_t            exp_data_i,
    output int               checks_o,
    output int               errors_o
);

    logic rst_q;
    logic pending;
    logic pulse_seen;
    // edge that produced the values seen now, counted from the read command
    int   edges;

    always @(posedge clk_i) begin
        if (rst_i) begin
            rst_q      = 1'b1;
            pending    = 1'b0;
            pulse_seen = 1'b0;
            edges      = 0;
            checks_o   = 0;
            errors_o   = 0;
        end else begin
            if (rst_q) begin
                checks_o++;
                if (busy_i || ret_valid_i) begin
                    errors_o++;
                    $display("tpu_busy_o or ret_valid_o high right after reset at %0t", $time);
                end
            end
            rst_q = 1'b0;

            if (ret_valid_i) begin
                checks_o++;
                if (!pending) begin
                    errors_o++;
                    $display("ret_valid_o pulse at %0t without a pending read", $time);
                end else if (edges != 3) begin
                    errors_o++;
                    $display("ret_valid_o came %0d cycles after the read, not 3", edges);
                end
                if (!busy_i) begin
                    errors_o++;
                    $display("tpu_busy_o low during the ret_valid_o pulse at %0t", $time);
                end
                if (ret_data_i !== exp_data_i) begin
                    errors_o++;
                    $display("FAIL time=%0t signal=ret_data_o got=%08h expected=%08h",
                             $time, ret_data_i, exp_data_i);
                end
                pending    = 1'b0;
                pulse_seen = 1'b1;
            end else if (pulse_seen) begin
                // busy has to drop together with the pulse
                pulse_seen = 1'b0;
                checks_o++;
                if (busy_i) begin
                    errors_o++;
                    $display("tpu_busy_o still high after ret_valid_o fell at %0t", $time);
                end
            end

            if (pending) begin
                edges++;
            end
            if (cmd_valid_i && cmd_i == SW_READ_DATA && !busy_i) begin
                pending = 1'b1;
                edges   = 0;
            end
        end
    end

endmodule

// File: bench/tpu_assertions.sv
`timescale 1ns/10ps

module tpu_assertions
    import tpu_data_pkg::*;
(
    input logic  clk_i,
    input logic  rst_i,
    input logic  ret_valid_i,
    input word_t ret_data_i,
    input logic  busy_i
);

    // count of failed assertions for the end of run summary
    int fail_cnt = 0;

    // readout is a single-cycle pulse
    a_one_pulse : assert property (
        @(posedge clk_i) disable iff (rst_i) ret_valid_i |=> !ret_valid_i
    ) else begin
        fail_cnt++;
        $error("ret_valid_o high for two cycles in a row");
    end

    a_data_zero : assert property (
        @(posedge clk_i) disable iff (rst_i) !ret_valid_i |-> ret_data_i == '0
    ) else begin
        fail_cnt++;
        $error("ret_data_o nonzero while ret_valid_o is low");
    end

    // first cycle out of reset
    a_idle_after_reset : assert property (
        @(posedge clk_i) $past(rst_i) && !rst_i |-> !busy_i
    ) else begin
        fail_cnt++;
        $error("tpu_busy_o high in the cycle after reset");
    end

endmodule

bind tpu_top tpu_assertions u_asrt (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .ret_valid_i (ret_valid_o),
    .ret_data_i  (ret_data_o),
    .busy_i      (tpu_busy_o)
);

// File: bench/tpu_tb.sv
`timescale 1ns/10ps

module tpu_tb
    import tpu_cmd_pkg::*;
    import tpu_data_pkg::*;
();

    localparam int MAX_K = 6;
    localparam int MAX_D = 8;

    logic               clk_i;
    logic               rst_i;
    logic               cmd_valid_i;
    logic [CMD_W-1:0]   cmd_i;
    logic [PARAM_W-1:0] param_1_i;
    logic [PARAM_W-1:0] param_2_i;
    logic               ret_valid_o;
    logic [PARAM_W-1:0] ret_data_o;
    logic               tpu_busy_o;

    // reference operands and the sizes of the last convolution
    word_t a_mat [MAX_D][MAX_K];
    word_t b_mat [MAX_K][MAX_D];
    int    k_dim, m_dim, n_dim;

    word_t exp_data;
    int    seed;
    int    checks;
    int    chk_errors;
    int    tb_errors;
    int    prev_errors;

    tpu_top dut_i (
        .clk_i, .rst_i, .cmd_valid_i, .cmd_i, .param_1_i, .param_2_i,
        .ret_valid_o, .ret_data_o, .tpu_busy_o
    );

    tpu_checker u_chk (
        .clk_i, .rst_i, .cmd_valid_i, .cmd_i,
        .busy_i      (tpu_busy_o),
        .ret_valid_i (ret_valid_o),
        .ret_data_i  (ret_data_o),
        .exp_data_i  (exp_data),
        .checks_o    (checks),
        .errors_o    (chk_errors)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ##################################################
    // reference model
    // ##################################################
    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // bank in bits 1:0, address above
    function automatic word_t operand_slot(input int lane, input int k);
        return word_t'(((lane / 4) * k_dim + k) * 4 + lane % 4);
    endfunction

    function automatic word_t model_elem(input int tile, input int elem);
        int    row;
        int    col;
        word_t sum;
        row = 4 * (tile % (m_dim / 4)) + elem / 4;
        col = 4 * (tile / (m_dim / 4)) + elem % 4;
        sum = '0;
        for (int k = 0; k < k_dim; k++) begin
            sum = sum + a_mat[row][k] * b_mat[k][col];
        end
        return sum;
    endfunction

    function automatic int total_errors();
        return chk_errors + tb_errors + dut_i.u_asrt.fail_cnt;
    endfunction

    // ##################################################
    // command driving and waits
    // ##################################################
    task automatic send_cmd(input opcode_t op, input word_t p1, input word_t p2);
        @(negedge clk_i);
        cmd_valid_i <= 1'b1;
        cmd_i       <= op;
        param_1_i   <= p1;
        param_2_i   <= p2;
        @(negedge clk_i);
        cmd_valid_i <= 1'b0;
    endtask

    task automatic end_run();
        $display("done: %0d checks, %0d errors", checks, total_errors());
        if (total_errors() == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (tpu_busy_o && n < limit) begin
            @(negedge clk_i);
            n++;
        end
        if (tpu_busy_o) begin
            $display("timeout: tpu_busy_o stayed high for %0d cycles", limit);
            tb_errors++;
            end_run();
        end
    endtask

    task automatic wait_ret(input int limit);
        int n;
        n = 0;
        while (!ret_valid_o && n < limit) begin
            @(negedge clk_i);
            n++;
        end
        if (!ret_valid_o) begin
            $display("timeout: no ret_valid_o pulse within %0d cycles of a read", limit);
            tb_errors++;
            end_run();
        end
    endtask

    task automatic run_conv(input int k_val, input int m_val, input int n_val);
        k_dim = k_val;
        m_dim = m_val;
        n_dim = n_val;
        send_cmd(SET_KMN, word_t'(KMN_K), word_t'(k_val));
        send_cmd(SET_KMN, word_t'(KMN_M), word_t'(m_val));
        send_cmd(SET_KMN, word_t'(KMN_N), word_t'(n_val));
        for (int r = 0; r < m_dim; r++) begin
            for (int k = 0; k < k_dim; k++) begin
                a_mat[r][k] = $random(seed);
                send_cmd(SW_WRITE_DATA, a_mat[r][k], operand_slot(r, k));
            end
        end
        for (int k = 0; k < k_dim; k++) begin
            for (int c = 0; c < n_dim; c++) begin
                b_mat[k][c] = $random(seed);
                send_cmd(SW_WRITE_WEIGHT, b_mat[k][c], operand_slot(c, k));
            end
        end
        send_cmd(TRIGGER_CONV, '0, '0);
        wait_idle(1000);
    endtask

    // the checker compares the pulse against exp_data
    task automatic read_elem(input int tile, input int elem);
        exp_data = model_elem(tile, elem);
        send_cmd(SW_READ_DATA, word_t'(elem), word_t'(tile));
        wait_ret(20);
        wait_idle(20);
    endtask

    task automatic read_all();
        for (int t = 0; t < (m_dim / 4) * (n_dim / 4); t++) begin
            for (int e = 0; e < 16; e++) begin
                read_elem(t, e);
            end
        end
    endtask

    task automatic report_test(input string name);
        int errs;
        errs = total_errors() - prev_errors;
        prev_errors = total_errors();
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errs);
        end
    endtask

    // ##################################################
    // test sequence
    // ##################################################
    initial begin
        int k_val;
        int m_val;
        int n_val;
        int tile;
        int elem;
        seed        = 34;
        rst_i       = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        param_1_i   = '0;
        param_2_i   = '0;
        exp_data    = '0;
        tb_errors   = 0;
        prev_errors = 0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i <= 1'b0;
        repeat (2) @(negedge clk_i);
        report_test("reset state");

        k_val = rand_range(2, 6);
        run_conv(k_val, 4, 4);
        read_all();
        report_test("single tile");

        k_val = rand_range(2, 6);
        run_conv(k_val, 8, 8);
        read_all();
        report_test("four tiles");

        // new sizes and operands over the old results
        k_val = rand_range(2, 6);
        m_val = 4 * rand_range(1, 2);
        // one of M and N is 4, the other 8
        n_val = 12 - m_val;
        run_conv(k_val, m_val, n_val);
        read_all();
        report_test("second conv overwrite");

        for (int i = 0; i < 6; i++) begin
            tile = rand_range(0, (m_dim / 4) * (n_dim / 4) - 1);
            elem = rand_range(0, 15);
            read_elem(tile, elem);
        end
        report_test("read timing");
        end_run();
    end

endmodule

// File: tpu_top.f
hw/tpu_cmd_pkg.sv
hw/tpu_data_pkg.sv
hw/tile_if.sv
hw/tpu_ctrl_fsm.sv
hw/tile_counter.sv
hw/operand_buffer.sv
hw/mac_array.sv
hw/result_buffer.sv
hw/tpu_top.sv
bench/tpu_checker.sv
bench/tpu_assertions.sv
bench/tpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the TPU testbench with Verilator, run it and check the log
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tpu_tb \
    -f tpu_top.f \
    -o tpu_sim

./obj_dir/tpu_sim +verilator+error+limit+100 | tee sim.log

grep -q "TEST PASSED" sim.log
echo "simulation passed"
